/* verilog/iq_pkg.sv */
package iq_pkg;

    // data word, in-flight result tag, ALU opcode
    typedef logic [31:0] word_t;
    typedef logic [3:0]  tag_t;
    typedef logic [2:0]  alu_op_t;

    // ----------------------------------------
    // opcode encodings
    // ----------------------------------------
    localparam alu_op_t OP_ADD = 3'd0;
    localparam alu_op_t OP_SUB = 3'd1;
    localparam alu_op_t OP_AND = 3'd2;
    localparam alu_op_t OP_OR  = 3'd3;
    localparam alu_op_t OP_XOR = 3'd4;
    // shift amount from the low 5 bits of operand 1
    localparam alu_op_t OP_SLL = 3'd5;
    localparam alu_op_t OP_SRL = 3'd6;
    // signed compare, result is 1 or 0
    localparam alu_op_t OP_SLT = 3'd7;

    // queue size defaults, IQ_SIZE must be a power of two in 2..16
    localparam int DEF_IQ_SIZE      = 4;
    localparam int DEF_AGING_LENGTH = 4;

    // operand capture from either result bus
    // returns {ready, data} after looking at both buses this cycle
    function automatic logic [$bits(word_t):0] snoop_src(
        input logic  rdy,
        input tag_t  tag,
        input word_t data,
        input logic  int_valid,
        input tag_t  int_tag,
        input word_t int_data,
        input logic  ext_valid,
        input tag_t  ext_tag,
        input word_t ext_data
    );
        logic [$bits(word_t):0] res;
        res = {rdy, data};
        if (!rdy && int_valid && (int_tag == tag)) begin
            res = {1'b1, int_data};
        end else if (!rdy && ext_valid && (ext_tag == tag)) begin
            res = {1'b1, ext_data};
        end
        return res;
    endfunction

endpackage

/* verilog/iq_entry.sv */
`timescale 1ns/10ps

module iq_entry (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            init_i,
    input  iq_pkg::alu_op_t op_i,
    input  iq_pkg::tag_t    dst_tag_i,
    input  iq_pkg::tag_t    src0_tag_i,
    input  iq_pkg::word_t   src0_data_i,
    input  logic            src0_rdy_i,
    input  iq_pkg::tag_t    src1_tag_i,
    input  iq_pkg::word_t   src1_data_i,
    input  logic            src1_rdy_i,
    input  logic            int_cdb_valid_i,
    input  iq_pkg::tag_t    int_cdb_tag_i,
    input  iq_pkg::word_t   int_cdb_data_i,
    input  logic            ext_cdb_valid_i,
    input  iq_pkg::tag_t    ext_cdb_tag_i,
    input  iq_pkg::word_t   ext_cdb_data_i,
    input  logic            select_i,
    output logic            busy_o,
    output logic            ready_o,
    output iq_pkg::alu_op_t op_o,
    output iq_pkg::tag_t    dst_tag_o,
    output iq_pkg::word_t   a_o,
    output iq_pkg::word_t   b_o
);
    import iq_pkg::*;

    logic       busy_q;
    alu_op_t    op_q;
    tag_t       dst_tag_q;
    tag_t       tag_q  [2];
    word_t      data_q [2];
    logic [1:0] rdy_q;

    tag_t       cur_tag  [2];
    word_t      cur_data [2];
    logic [1:0] cur_rdy;
    word_t      nxt_data [2];
    logic [1:0] nxt_rdy;

    // incoming sources on init, held sources otherwise
    always_comb begin
        if (init_i) begin
            cur_tag[0]  = src0_tag_i;
            cur_data[0] = src0_data_i;
            cur_rdy[0]  = src0_rdy_i;
            cur_tag[1]  = src1_tag_i;
            cur_data[1] = src1_data_i;
            cur_rdy[1]  = src1_rdy_i;
        end else begin
            cur_tag  = tag_q;
            cur_data = data_q;
            cur_rdy  = rdy_q;
        end
        for (int s = 0; s < 2; s++) begin
            {nxt_rdy[s], nxt_data[s]} = snoop_src(cur_rdy[s], cur_tag[s], cur_data[s],
                int_cdb_valid_i, int_cdb_tag_i, int_cdb_data_i,
                ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_data_i);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (init_i) begin
            busy_q <= 1'b1;
        end else if (select_i) begin
            busy_q <= 1'b0;
        end
    end

    // payload, operands keep snooping while the slot is held
    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q      <= op_i;
            dst_tag_q <= dst_tag_i;
            tag_q[0]  <= src0_tag_i;
            tag_q[1]  <= src1_tag_i;
        end
        data_q <= nxt_data;
        rdy_q  <= nxt_rdy;
    end

    assign busy_o    = busy_q;
    assign ready_o   = busy_q & (&rdy_q);
    assign op_o      = op_q;
    assign dst_tag_o = dst_tag_q;
    assign a_o       = data_q[0];
    assign b_o       = data_q[1];

endmodule

/* verilog/alu_iq.sv */
`timescale 1ns/10ps

module alu_iq #(
    parameter int IQ_SIZE      = iq_pkg::DEF_IQ_SIZE,
    parameter int AGING_LENGTH = iq_pkg::DEF_AGING_LENGTH
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            disp_valid_i,
    input  iq_pkg::alu_op_t disp_op_i,
    input  iq_pkg::tag_t    disp_dst_tag_i,
    input  iq_pkg::tag_t    disp_src0_tag_i,
    input  iq_pkg::word_t   disp_src0_data_i,
    input  logic            disp_src0_rdy_i,
    input  iq_pkg::tag_t    disp_src1_tag_i,
    input  iq_pkg::word_t   disp_src1_data_i,
    input  logic            disp_src1_rdy_i,
    output logic            disp_ready_o,
    input  logic            int_cdb_valid_i,
    input  iq_pkg::tag_t    int_cdb_tag_i,
    input  iq_pkg::word_t   int_cdb_data_i,
    input  logic            ext_cdb_valid_i,
    input  iq_pkg::tag_t    ext_cdb_tag_i,
    input  iq_pkg::word_t   ext_cdb_data_i,
    output logic            iss_valid_o,
    output iq_pkg::alu_op_t iss_op_o,
    output iq_pkg::tag_t    iss_tag_o,
    output iq_pkg::word_t   iss_a_o,
    output iq_pkg::word_t   iss_b_o,
    input  logic            iss_ready_i
);
    import iq_pkg::*;

    localparam int IDX_W = $clog2(IQ_SIZE);
    localparam int NODES = 2 * IQ_SIZE - 1;
    localparam logic [AGING_LENGTH-1:0] AGE_ONE = AGING_LENGTH'(1);
    localparam logic [AGING_LENGTH-1:0] AGE_SAT = AGE_ONE << (AGING_LENGTH - 1);

    logic [IQ_SIZE-1:0] busy;
    logic [IQ_SIZE-1:0] ready;
    logic [IQ_SIZE-1:0] alloc;
    logic [IQ_SIZE-1:0] init;
    logic [IQ_SIZE-1:0] select;
    alu_op_t            ent_op  [IQ_SIZE];
    tag_t               ent_tag [IQ_SIZE];
    word_t              ent_a   [IQ_SIZE];
    word_t              ent_b   [IQ_SIZE];

    logic [AGING_LENGTH-1:0] age_q    [IQ_SIZE];
    logic [AGING_LENGTH:0]   node_key [NODES];
    logic [IDX_W-1:0]        node_idx [NODES];
    logic [IDX_W-1:0]        sel;

    // ----------------------------------------
    // allocation
    // ----------------------------------------
    // lowest clear bit of the busy vector
    assign alloc        = ~busy & (busy + 1'b1);
    assign init         = alloc & {IQ_SIZE{disp_valid_i}};
    assign disp_ready_o = ~(&busy);

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk,
            .rst_n_i,
            .flush_i,
            .init_i          (init[i]),
            .op_i            (disp_op_i),
            .dst_tag_i       (disp_dst_tag_i),
            .src0_tag_i      (disp_src0_tag_i),
            .src0_data_i     (disp_src0_data_i),
            .src0_rdy_i      (disp_src0_rdy_i),
            .src1_tag_i      (disp_src1_tag_i),
            .src1_data_i     (disp_src1_data_i),
            .src1_rdy_i      (disp_src1_rdy_i),
            .int_cdb_valid_i, .int_cdb_tag_i, .int_cdb_data_i,
            .ext_cdb_valid_i, .ext_cdb_tag_i, .ext_cdb_data_i,
            .select_i        (select[i]),
            .busy_o          (busy[i]),
            .ready_o         (ready[i]),
            .op_o            (ent_op[i]),
            .dst_tag_o       (ent_tag[i]),
            .a_o             (ent_a[i]),
            .b_o             (ent_b[i])
        );
    end

    // ----------------------------------------
    // oldest-ready select tree
    // ----------------------------------------
    // leaves sit at NODES-IQ_SIZE.., node n has children 2n+1 and 2n+2
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_leaf
        assign node_key[IQ_SIZE-1+i] = {ready[i], age_q[i]};
        assign node_idx[IQ_SIZE-1+i] = IDX_W'(i);
    end

    // right side wins only when strictly larger, so ties keep the low index
    for (genvar n = 0; n < IQ_SIZE - 1; n++) begin : g_node
        assign node_key[n] = (node_key[2*n+2] > node_key[2*n+1]) ?
                             node_key[2*n+2] : node_key[2*n+1];
        assign node_idx[n] = (node_key[2*n+2] > node_key[2*n+1]) ?
                             node_idx[2*n+2] : node_idx[2*n+1];
    end

    assign sel         = node_idx[0];
    assign iss_valid_o = node_key[0][AGING_LENGTH];
    assign iss_op_o    = ent_op[sel];
    assign iss_tag_o   = ent_tag[sel];
    assign iss_a_o     = ent_a[sel];
    assign iss_b_o     = ent_b[sel];
    assign select      = (iss_valid_o && iss_ready_i) ? (IQ_SIZE'(1) << sel) : '0;

    // one-hot age, saturates at the top bit
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (flush_i || select[i]) begin
                    age_q[i] <= '0;
                end else if (init[i]) begin
                    age_q[i] <= AGE_ONE;
                end else if (busy[i] && (age_q[i] != AGE_SAT)) begin
                    age_q[i] <= age_q[i] << 1;
                end
            end
        end
    end

endmodule

/* verilog/dispatch_stage.sv */
`timescale 1ns/10ps

module dispatch_stage (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  iq_pkg::alu_op_t in_op_i,
    input  iq_pkg::tag_t    in_dst_tag_i,
    input  iq_pkg::tag_t    in_src0_tag_i,
    input  iq_pkg::word_t   in_src0_data_i,
    input  logic            in_src0_rdy_i,
    input  iq_pkg::tag_t    in_src1_tag_i,
    input  iq_pkg::word_t   in_src1_data_i,
    input  logic            in_src1_rdy_i,
    input  logic            int_cdb_valid_i,
    input  iq_pkg::tag_t    int_cdb_tag_i,
    input  iq_pkg::word_t   int_cdb_data_i,
    input  logic            ext_cdb_valid_i,
    input  iq_pkg::tag_t    ext_cdb_tag_i,
    input  iq_pkg::word_t   ext_cdb_data_i,
    output logic            disp_valid_o,
    input  logic            disp_ready_i,
    output iq_pkg::alu_op_t disp_op_o,
    output iq_pkg::tag_t    disp_dst_tag_o,
    output iq_pkg::tag_t    disp_src0_tag_o,
    output iq_pkg::word_t   disp_src0_data_o,
    output logic            disp_src0_rdy_o,
    output iq_pkg::tag_t    disp_src1_tag_o,
    output iq_pkg::word_t   disp_src1_data_o,
    output logic            disp_src1_rdy_o
);
    import iq_pkg::*;

    typedef enum logic {EMPTY, FULL} skid_state_t;

    skid_state_t state_q;
    logic        in_fire;
    alu_op_t     op_q;
    tag_t        dst_tag_q;
    tag_t        tag_q  [2];
    word_t       data_q [2];
    logic [1:0]  rdy_q;
    word_t       cur_data [2];
    logic [1:0]  cur_rdy;
    word_t       nxt_data [2];
    logic [1:0]  nxt_rdy;

    // room when empty or the queue takes the held instruction now
    assign in_ready_o = (state_q == EMPTY) || disp_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_comb begin
        cur_data[0] = in_fire ? in_src0_data_i : data_q[0];
        cur_rdy[0]  = in_fire ? in_src0_rdy_i  : rdy_q[0];
        cur_data[1] = in_fire ? in_src1_data_i : data_q[1];
        cur_rdy[1]  = in_fire ? in_src1_rdy_i  : rdy_q[1];
        {nxt_rdy[0], nxt_data[0]} = snoop_src(cur_rdy[0],
            in_fire ? in_src0_tag_i : tag_q[0], cur_data[0],
            int_cdb_valid_i, int_cdb_tag_i, int_cdb_data_i,
            ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_data_i);
        {nxt_rdy[1], nxt_data[1]} = snoop_src(cur_rdy[1],
            in_fire ? in_src1_tag_i : tag_q[1], cur_data[1],
            int_cdb_valid_i, int_cdb_tag_i, int_cdb_data_i,
            ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_data_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EMPTY;
        end else if (flush_i) begin
            state_q <= EMPTY;
        end else if (in_fire) begin
            state_q <= FULL;
        end else if (disp_ready_i) begin
            state_q <= EMPTY;
        end
    end

    // held operands still pick up results during a stall
    always_ff @(posedge clk) begin
        if (in_fire) begin
            op_q      <= in_op_i;
            dst_tag_q <= in_dst_tag_i;
            tag_q[0]  <= in_src0_tag_i;
            tag_q[1]  <= in_src1_tag_i;
        end
        data_q <= nxt_data;
        rdy_q  <= nxt_rdy;
    end

    assign disp_valid_o     = (state_q == FULL);
    assign disp_op_o        = op_q;
    assign disp_dst_tag_o   = dst_tag_q;
    assign disp_src0_tag_o  = tag_q[0];
    assign disp_src0_data_o = data_q[0];
    assign disp_src0_rdy_o  = rdy_q[0];
    assign disp_src1_tag_o  = tag_q[1];
    assign disp_src1_data_o = data_q[1];
    assign disp_src1_rdy_o  = rdy_q[1];

endmodule

/* verilog/alu_exec.sv */
`timescale 1ns/10ps

module alu_exec (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            iss_valid_i,
    input  iq_pkg::alu_op_t iss_op_i,
    input  iq_pkg::tag_t    iss_tag_i,
    input  iq_pkg::word_t   iss_a_i,
    input  iq_pkg::word_t   iss_b_i,
    output logic            iss_ready_o,
    output logic            result_valid_o,
    output iq_pkg::tag_t    result_tag_o,
    output iq_pkg::word_t   result_data_o,
    input  logic            result_ready_i
);
    import iq_pkg::*;

    logic  res_valid_q;
    tag_t  res_tag_q;
    word_t res_data_q;
    word_t alu_res;

    // ----------------------------------------
    // opcode evaluation
    // ----------------------------------------
    always_comb begin
        case (iss_op_i)
            OP_ADD:  alu_res = iss_a_i + iss_b_i;
            OP_SUB:  alu_res = iss_a_i - iss_b_i;
            OP_AND:  alu_res = iss_a_i & iss_b_i;
            OP_OR:   alu_res = iss_a_i | iss_b_i;
            OP_XOR:  alu_res = iss_a_i ^ iss_b_i;
            OP_SLL:  alu_res = iss_a_i << iss_b_i[4:0];
            OP_SRL:  alu_res = iss_a_i >> iss_b_i[4:0];
            OP_SLT:  alu_res = {31'd0, $signed(iss_a_i) < $signed(iss_b_i)};
            default: alu_res = '0;
        endcase
    end

    // ----------------------------------------
    // one-entry result register
    // ----------------------------------------
    // takes a new result when empty or draining
    assign iss_ready_o = !res_valid_q || result_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else if (iss_ready_o) begin
            res_valid_q <= iss_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid_i && iss_ready_o) begin
            res_tag_q  <= iss_tag_i;
            res_data_q <= alu_res;
        end
    end

    assign result_valid_o = res_valid_q;
    assign result_tag_o   = res_tag_q;
    assign result_data_o  = res_data_q;

endmodule

/* verilog/iq_top.sv */
`timescale 1ns/10ps

module iq_top #(
    parameter int IQ_SIZE      = iq_pkg::DEF_IQ_SIZE,
    parameter int AGING_LENGTH = iq_pkg::DEF_AGING_LENGTH
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  iq_pkg::alu_op_t in_op_i,
    input  iq_pkg::tag_t    in_dst_tag_i,
    input  iq_pkg::tag_t    in_src0_tag_i,
    input  iq_pkg::word_t   in_src0_data_i,
    input  logic            in_src0_rdy_i,
    input  iq_pkg::tag_t    in_src1_tag_i,
    input  iq_pkg::word_t   in_src1_data_i,
    input  logic            in_src1_rdy_i,
    input  logic            ext_cdb_valid_i,
    input  iq_pkg::tag_t    ext_cdb_tag_i,
    input  iq_pkg::word_t   ext_cdb_data_i,
    output logic            result_valid_o,
    output iq_pkg::tag_t    result_tag_o,
    output iq_pkg::word_t   result_data_o,
    input  logic            result_ready_i
);
    import iq_pkg::*;

    logic    disp_valid;
    logic    disp_ready;
    alu_op_t disp_op;
    tag_t    disp_dst_tag;
    tag_t    disp_src0_tag;
    word_t   disp_src0_data;
    logic    disp_src0_rdy;
    tag_t    disp_src1_tag;
    word_t   disp_src1_data;
    logic    disp_src1_rdy;
    logic    iss_valid;
    logic    iss_ready;
    alu_op_t iss_op;
    tag_t    iss_tag;
    word_t   iss_a;
    word_t   iss_b;
    logic    cdb_valid;

    // internal CDB write is the result handshake
    assign cdb_valid = result_valid_o && result_ready_i;

    dispatch_stage u_dispatch (
        .clk, .rst_n_i, .flush_i,
        .in_valid_i, .in_ready_o, .in_op_i, .in_dst_tag_i,
        .in_src0_tag_i, .in_src0_data_i, .in_src0_rdy_i,
        .in_src1_tag_i, .in_src1_data_i, .in_src1_rdy_i,
        .int_cdb_valid_i  (cdb_valid),
        .int_cdb_tag_i    (result_tag_o),
        .int_cdb_data_i   (result_data_o),
        .ext_cdb_valid_i, .ext_cdb_tag_i, .ext_cdb_data_i,
        .disp_valid_o     (disp_valid),
        .disp_ready_i     (disp_ready),
        .disp_op_o        (disp_op),
        .disp_dst_tag_o   (disp_dst_tag),
        .disp_src0_tag_o  (disp_src0_tag),
        .disp_src0_data_o (disp_src0_data),
        .disp_src0_rdy_o  (disp_src0_rdy),
        .disp_src1_tag_o  (disp_src1_tag),
        .disp_src1_data_o (disp_src1_data),
        .disp_src1_rdy_o  (disp_src1_rdy)
    );

    alu_iq #(
        .IQ_SIZE      (IQ_SIZE),
        .AGING_LENGTH (AGING_LENGTH)
    ) u_iq (
        .clk, .rst_n_i, .flush_i,
        .disp_valid_i     (disp_valid),
        .disp_op_i        (disp_op),
        .disp_dst_tag_i   (disp_dst_tag),
        .disp_src0_tag_i  (disp_src0_tag),
        .disp_src0_data_i (disp_src0_data),
        .disp_src0_rdy_i  (disp_src0_rdy),
        .disp_src1_tag_i  (disp_src1_tag),
        .disp_src1_data_i (disp_src1_data),
        .disp_src1_rdy_i  (disp_src1_rdy),
        .disp_ready_o     (disp_ready),
        .int_cdb_valid_i  (cdb_valid),
        .int_cdb_tag_i    (result_tag_o),
        .int_cdb_data_i   (result_data_o),
        .ext_cdb_valid_i, .ext_cdb_tag_i, .ext_cdb_data_i,
        .iss_valid_o      (iss_valid),
        .iss_op_o         (iss_op),
        .iss_tag_o        (iss_tag),
        .iss_a_o          (iss_a),
        .iss_b_o          (iss_b),
        .iss_ready_i      (iss_ready)
    );

    alu_exec u_exec (
        .clk, .rst_n_i, .flush_i,
        .iss_valid_i (iss_valid),
        .iss_op_i    (iss_op),
        .iss_tag_i   (iss_tag),
        .iss_a_i     (iss_a),
        .iss_b_i     (iss_b),
        .iss_ready_o (iss_ready),
        .result_valid_o, .result_tag_o, .result_data_o, .result_ready_i
    );

endmodule

/* verif/iq_tb.sv */
`timescale 1ns/10ps

module iq_tb;
    import iq_pkg::*;

    localparam int TIMEOUT = 2000;

    logic    clk;
    logic    rst_n_i;
    logic    flush_i;
    logic    in_valid_i;
    logic    in_ready_o;
    alu_op_t in_op_i;
    tag_t    in_dst_tag_i;
    tag_t    in_src0_tag_i;
    word_t   in_src0_data_i;
    logic    in_src0_rdy_i;
    tag_t    in_src1_tag_i;
    word_t   in_src1_data_i;
    logic    in_src1_rdy_i;
    logic    ext_cdb_valid_i;
    tag_t    ext_cdb_tag_i;
    word_t   ext_cdb_data_i;
    logic    result_valid_o;
    tag_t    result_tag_o;
    word_t   result_data_o;
    logic    result_ready_i;

    // scoreboard indexed by destination tag
    logic        pending  [16];
    logic        done     [16];
    word_t       expected [16];
    logic [1:0]  dep_on   [16];
    tag_t        dep_tag  [16][2];
    tag_t        order_q  [$];
    logic        ordered;
    int          outstanding;

    int     errors;
    int     test_errors;
    int     test_results;
    int     total_results;
    int     tests;
    logic   aborted;
    int     ready_mode;
    integer seed;
    logic [31:0] rnd;

    iq_top #(
        .IQ_SIZE      (DEF_IQ_SIZE),
        .AGING_LENGTH (DEF_AGING_LENGTH)
    ) dut_i (
        .clk, .rst_n_i, .flush_i,
        .in_valid_i, .in_ready_o, .in_op_i, .in_dst_tag_i,
        .in_src0_tag_i, .in_src0_data_i, .in_src0_rdy_i,
        .in_src1_tag_i, .in_src1_data_i, .in_src1_rdy_i,
        .ext_cdb_valid_i, .ext_cdb_tag_i, .ext_cdb_data_i,
        .result_valid_o, .result_tag_o, .result_data_o, .result_ready_i
    );

    always #20 clk = ~clk;

    // result_ready_i is random in mode 0, held low in mode 1 and high in mode 2
    always @(posedge clk) begin
        rnd = $random(seed);
        if (ready_mode == 1) begin
            result_ready_i <= 1'b0;
        end else if (ready_mode == 2) begin
            result_ready_i <= 1'b1;
        end else begin
            result_ready_i <= rnd[0];
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %0s: got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // ----------------------------------------
    // result monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n_i && result_valid_o && result_ready_i) begin
            if (!pending[result_tag_o]) begin
                $display("unexpected result with tag %h", result_tag_o);
                errors++;
                test_errors++;
            end else begin
                check_value("result_data_o", result_data_o, expected[result_tag_o]);
                for (int s = 0; s < 2; s++) begin
                    if (dep_on[result_tag_o][s] && !done[dep_tag[result_tag_o][s]]) begin
                        $display("result for tag %h came before its source tag %h",
                                 result_tag_o, dep_tag[result_tag_o][s]);
                        errors++;
                        test_errors++;
                    end
                end
                if (ordered) begin
                    if (order_q.size() == 0) begin
                        $display("result for tag %h arrived out of sequence", result_tag_o);
                        errors++;
                        test_errors++;
                    end else begin
                        check_value("result_tag_o", {28'd0, result_tag_o},
                                    {28'd0, order_q.pop_front()});
                    end
                end
                pending[result_tag_o] = 1'b0;
                done[result_tag_o]    = 1'b1;
                outstanding--;
                test_results++;
                total_results++;
            end
        end
    end

    // present one instruction and wait for its handshake
    task automatic drive_instr(input logic [31:0] f[9]);
        int   cnt;
        logic accepted;
        cnt      = 0;
        accepted = 1'b0;
        in_valid_i     <= 1'b1;
        in_op_i        <= f[0][2:0];
        in_dst_tag_i   <= f[1][3:0];
        in_src0_tag_i  <= f[2][3:0];
        in_src0_data_i <= f[3];
        in_src0_rdy_i  <= f[4][0];
        in_src1_tag_i  <= f[5][3:0];
        in_src1_data_i <= f[6];
        in_src1_rdy_i  <= f[7][0];
        while (!accepted && !aborted) begin
            @(negedge clk);
            cnt++;
            if (in_ready_o) begin
                accepted = 1'b1;
            end else if (cnt > TIMEOUT) begin
                $display("timeout waiting for dispatch to accept tag %h", f[1][3:0]);
                aborted = 1'b1;
            end
        end
        if (accepted) begin
            @(posedge clk);
            pending[f[1][3:0]]    = 1'b1;
            expected[f[1][3:0]]   = f[8];
            dep_on[f[1][3:0]]     = {~f[7][0], ~f[4][0]};
            dep_tag[f[1][3:0]][0] = f[2][3:0];
            dep_tag[f[1][3:0]][1] = f[5][3:0];
            if (ordered) begin
                order_q.push_back(f[1][3:0]);
            end
            outstanding++;
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (outstanding != 0 && !aborted) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("timeout with %0d results still missing", outstanding);
                aborted = 1'b1;
            end
        end
        @(posedge clk);
    endtask

    // ----------------------------------------
    // stimulus from the test file
    // ----------------------------------------
    initial begin
        int              fd;
        int              code;
        logic [7:0]      kind;
        logic [31:0]     f [9];
        logic [31:0]     v0;
        logic [31:0]     v1;
        logic [8*128-1:0] skip_line;
        logic [8*32-1:0] name;

        clk             = 0;
        rst_n_i         = 0;
        flush_i         = 0;
        in_valid_i      = 0;
        in_op_i         = '0;
        in_dst_tag_i    = '0;
        in_src0_tag_i   = '0;
        in_src0_data_i  = '0;
        in_src0_rdy_i   = 0;
        in_src1_tag_i   = '0;
        in_src1_data_i  = '0;
        in_src1_rdy_i   = 0;
        ext_cdb_valid_i = 0;
        ext_cdb_tag_i   = '0;
        ext_cdb_data_i  = '0;
        result_ready_i  = 0;
        seed            = 3440;
        ready_mode      = 0;
        ordered         = 0;
        outstanding     = 0;
        errors          = 0;
        test_errors     = 0;
        test_results    = 0;
        total_results   = 0;
        tests           = 0;
        aborted         = 0;
        for (int t = 0; t < 16; t++) begin
            pending[t] = 0;
            done[t]    = 0;
            dep_on[t]  = '0;
        end

        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);

        fd = $fopen("verif/iq_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/iq_tests.txt");
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            if (kind != "I") begin
                in_valid_i <= 1'b0;
            end
            case (kind)
                "#": code = $fgets(skip_line, fd);
                "I": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                   f[3], f[4], f[5], f[6], f[7], f[8]);
                    drive_instr(f);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h", v0, v1);
                    ext_cdb_valid_i <= 1'b1;
                    ext_cdb_tag_i   <= v0[3:0];
                    ext_cdb_data_i  <= v1;
                    done[v0[3:0]] = 1'b1;
                    @(posedge clk);
                    ext_cdb_valid_i <= 1'b0;
                end
                "F": begin
                    flush_i <= 1'b1;
                    @(posedge clk);
                    flush_i <= 1'b0;
                    for (int t = 0; t < 16; t++) begin
                        pending[t] = 1'b0;
                    end
                    order_q.delete();
                    outstanding = 0;
                end
                "P": begin
                    code = $fscanf(fd, "%h", v0);
                    ready_mode <= int'(v0);
                end
                "Q": ordered = 1'b1;
                "R": begin
                    code = $fscanf(fd, "%h", v0);
                    @(negedge clk);
                    check_value("in_ready_o", {31'd0, in_ready_o}, v0);
                    @(posedge clk);
                end
                "T": begin
                    code = $fscanf(fd, "%s", name);
                    wait_drain();
                    $display("test %0s: %0d results, %0d errors", name, test_results,
                             test_errors);
                    tests++;
                    test_results = 0;
                    test_errors  = 0;
                    ordered      = 1'b0;
                    order_q.delete();
                    for (int t = 0; t < 16; t++) begin
                        done[t] = 1'b0;
                    end
                end
                default: begin
                    $display("unknown line type in test file");
                    aborted = 1'b1;
                end
            endcase
        end
        in_valid_i <= 1'b0;

        $display("%0d tests, %0d results, %0d errors", tests, total_results, errors);
        if (errors == 0 && !aborted) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/iq_pkg.sv
verilog/iq_entry.sv
verilog/alu_iq.sv
verilog/dispatch_stage.sv
verilog/alu_exec.sv
verilog/iq_top.sv
verif/iq_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module iq_tb -f verilog.f -o iq_sim
./obj_dir/iq_sim | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/iq_tests.txt */
# I op dst src0_tag src0_data src0_rdy src1_tag src1_data src1_rdy expected (hex)
# E tag data = external CDB write, P mode = result_ready mode, Q = ordered, R v, F, T name
I 0 1 0 00000005 1 0 00000003 1 00000008
I 1 2 0 00000003 1 0 00000005 1 fffffffe
I 2 3 0 0000ff0f 1 0 000f00ff 1 0000000f
I 3 4 0 0000f000 1 0 0000000f 1 0000f00f
I 4 5 0 aaaa5555 1 0 ffff0000 1 55555555
I 5 6 0 00000003 1 0 00000024 1 00000030
I 6 7 0 80000000 1 0 0000001f 1 00000001
I 7 8 0 ffffffff 1 0 00000001 1 00000001
I 7 9 0 00000005 1 0 fffffffe 1 00000000
T opcodes
I 0 1 0 00000010 1 0 00000020 1 00000030
I 1 2 1 00000000 0 0 00000005 1 0000002b
I 5 3 2 00000000 0 0 00000002 1 000000ac
I 0 4 3 00000000 0 0 00000030 1 000000dc
T chain
I 0 1 f 00000000 0 0 00000001 1 00000101
I 2 2 0 000000ff 1 0 0000000f 1 0000000f
E f 00000100
T ext
I 0 1 e 00000000 0 0 00000001 1 00000011
I 0 2 e 00000000 0 0 00000002 1 00000012
I 0 3 e 00000000 0 0 00000003 1 00000013
I 0 4 e 00000000 0 0 00000004 1 00000014
I 1 5 e 00000000 0 0 00000001 1 0000000f
R 0
E e 00000010
T stall
I 0 1 0 00000001 1 0 00000001 1 00000002
I 4 2 0 0000000f 1 0 000000f0 1 000000ff
I 1 3 0 00000100 1 0 00000001 1 000000ff
I 3 4 0 00001000 1 0 00000001 1 00001001
I 5 5 0 00000001 1 0 0000001f 1 80000000
I 6 6 0 00000100 1 0 00000004 1 00000010
I 2 7 0 12345678 1 0 0000ffff 1 00005678
I 7 8 0 00000002 1 0 00000003 1 00000001
T burst
P 1
Q
I 0 1 0 00000001 1 0 00000002 1 00000003
I 0 2 0 00000002 1 0 00000002 1 00000004
I 0 3 0 00000003 1 0 00000002 1 00000005
I 0 4 0 00000004 1 0 00000002 1 00000006
I 0 5 0 00000005 1 0 00000002 1 00000007
P 2
T age
P 1
I 0 1 0 00000001 1 0 00000001 1 00000002
I 0 2 d 00000000 0 0 00000001 1 00000009
F
P 0
I 0 3 0 00000002 1 0 00000003 1 00000005
I 0 4 3 00000000 0 0 00000004 1 00000009
T flush
